// File: verilog/reg_map_pkg.sv
`default_nettype none

package reg_map_pkg;

    // native register bus widths
    localparam int addr_width = 16;
    localparam int data_width = 32;

    // log2 of the bytes per word
    localparam int byte_trunc_bits = 2;

    // dispatcher window toward regslv_slv_map
    localparam int slv_addr_rem_bits = 13;
    localparam logic [addr_width-1:0] disp_base_addr = 16'h0000;
    localparam logic [addr_width-1:0] disp_window_size = 16'h12c8;

    // register offsets inside the slave
    localparam logic [addr_width-1:0] reg_id_addr = 16'h000;
    localparam logic [addr_width-1:0] reg_scratch_addr = 16'h004;
    localparam logic [addr_width-1:0] reg_ctrl_addr = 16'h008;
    localparam logic [addr_width-1:0] reg_wcount_addr = 16'h00c;

    localparam logic [data_width-1:0] reg_id_value = 32'h52454731;

    typedef enum logic [1:0] {
        bridge_idle,
        bridge_wait,
        bridge_resp
    } bridge_state_e;

    typedef enum logic [2:0] {
        sel_id,
        sel_scratch,
        sel_ctrl,
        sel_wcount,
        sel_none
    } reg_sel_e;

endpackage

`default_nettype wire

// File: verilog/wb_reg_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module wb_reg_bridge (
    input  wire                                   regdisp_disp_map_clk,
    input  wire                                   regdisp_disp_map_rst_n,
    input  wire                                   wb_cyc,
    input  wire                                   wb_stb,
    input  wire                                   wb_we,
    input  wire  [reg_map_pkg::addr_width-1:0]    wb_adr,
    input  wire  [reg_map_pkg::data_width-1:0]    wb_dat_w,
    input  wire                                   non_sec,
    input  wire                                   soft_rst,
    input  wire                                   ack_vld,
    input  wire                                   err,
    input  wire  [reg_map_pkg::data_width-1:0]    rd_data,
    output logic                                  wb_ack,
    output logic                                  wb_err,
    output logic [reg_map_pkg::data_width-1:0]    wb_dat_r,
    output logic                                  req_vld,
    output logic [reg_map_pkg::addr_width-1:0]    addr,
    output logic                                  wr_en,
    output logic                                  rd_en,
    output logic [reg_map_pkg::data_width-1:0]    wr_data,
    output logic                                  req_non_sec,
    output logic                                  req_soft_rst
);

    reg_map_pkg::bridge_state_e state;
    logic                       req_start;
    logic                       rsp_take;

    assign req_start = (state == reg_map_pkg::bridge_idle) && wb_cyc && wb_stb;
    assign rsp_take = (state == reg_map_pkg::bridge_wait) && ack_vld;

    // soft reset is a level, not part of the request
    assign req_soft_rst = soft_rst;

    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            state   <= reg_map_pkg::bridge_idle;
            req_vld <= 1'b0;
            wb_ack  <= 1'b0;
            wb_err  <= 1'b0;
        end else begin
            req_vld <= req_start;
            wb_ack  <= rsp_take && !err;
            wb_err  <= rsp_take && err;
            case (state)
                reg_map_pkg::bridge_idle: begin
                    if (req_start) begin
                        state <= reg_map_pkg::bridge_wait;
                    end
                end
                reg_map_pkg::bridge_wait: begin
                    if (ack_vld) begin
                        state <= reg_map_pkg::bridge_resp;
                    end
                end
                // master sees ack here and drops stb
                default: state <= reg_map_pkg::bridge_idle;
            endcase
        end
    end

    always_ff @(posedge regdisp_disp_map_clk) begin
        if (req_start) begin
            addr        <= wb_adr;
            wr_en       <= wb_we;
            rd_en       <= !wb_we;
            wr_data     <= wb_dat_w;
            req_non_sec <= non_sec;
        end
        if (rsp_take) begin
            wb_dat_r <= rd_data;
        end
    end

    // a native ack only comes back while a request is in flight
    assert property (@(posedge regdisp_disp_map_clk) disable iff (!regdisp_disp_map_rst_n)
        ack_vld |-> state == reg_map_pkg::bridge_wait);

endmodule

`default_nettype wire

// File: verilog/regdisp_disp_map.sv
`timescale 1ns/100ps
`default_nettype none

module regdisp_disp_map #(
    parameter bit insert_forward_ff = 1'b0,
    parameter bit insert_backward_ff = 1'b0
) (
    input  wire                                   regdisp_disp_map_clk,
    input  wire                                   regdisp_disp_map_rst_n,
    input  wire                                   upstream_req_vld,
    input  wire  [reg_map_pkg::addr_width-1:0]    upstream_addr,
    input  wire                                   upstream_wr_en,
    input  wire                                   upstream_rd_en,
    input  wire  [reg_map_pkg::data_width-1:0]    upstream_wr_data,
    input  wire                                   upstream_non_sec,
    input  wire                                   upstream_soft_rst,
    output logic                                  upstream_ack_vld,
    output logic                                  upstream_err,
    output logic [reg_map_pkg::data_width-1:0]    upstream_rd_data,
    output logic                                  downstream_req_vld,
    output logic [reg_map_pkg::addr_width-1:0]    downstream_addr,
    output logic                                  downstream_wr_en,
    output logic                                  downstream_rd_en,
    output logic [reg_map_pkg::data_width-1:0]    downstream_wr_data,
    output logic                                  downstream_non_sec,
    output logic                                  downstream_soft_rst,
    input  wire                                   downstream_ack_vld,
    input  wire                                   downstream_err,
    input  wire  [reg_map_pkg::data_width-1:0]    downstream_rd_data
);

    logic [reg_map_pkg::addr_width-1:0] word_addr;
    logic                               dec_slv_sel;
    logic                               dec_dummy_sel;
    logic                               dummy_ack_vld;
    logic                               imux_req_vld;
    logic [reg_map_pkg::addr_width-1:0] imux_addr;
    logic                               mux_ack_vld;
    logic                               mux_err;
    logic [reg_map_pkg::data_width-1:0] mux_rd_data;

    assign word_addr = {upstream_addr[reg_map_pkg::addr_width-1:reg_map_pkg::byte_trunc_bits],
                        {reg_map_pkg::byte_trunc_bits{1'b0}}};

    // window check in 17 bits so base plus size cannot wrap
    always_comb begin
        dec_slv_sel   = 1'b0;
        dec_dummy_sel = 1'b0;
        if (upstream_req_vld) begin
            if (word_addr >= reg_map_pkg::disp_base_addr &&
                {1'b0, word_addr} < {1'b0, reg_map_pkg::disp_base_addr} +
                                    {1'b0, reg_map_pkg::disp_window_size}) begin
                dec_slv_sel = 1'b1;
            end else begin
                dec_dummy_sel = 1'b1;
            end
        end
    end

    assign imux_req_vld = upstream_req_vld && dec_slv_sel;
    // slave sees its offset only
    assign imux_addr = {{(reg_map_pkg::addr_width - reg_map_pkg::slv_addr_rem_bits){1'b0}},
                        upstream_addr[reg_map_pkg::slv_addr_rem_bits-1:0]};

    generate
        if (insert_forward_ff) begin : g_forward_ff
            always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
                if (!regdisp_disp_map_rst_n) begin
                    downstream_req_vld  <= 1'b0;
                    downstream_soft_rst <= 1'b0;
                end else begin
                    downstream_req_vld  <= imux_req_vld;
                    downstream_soft_rst <= upstream_soft_rst;
                end
            end
            always_ff @(posedge regdisp_disp_map_clk) begin
                downstream_addr    <= imux_addr;
                downstream_wr_en   <= dec_slv_sel && upstream_wr_en;
                downstream_rd_en   <= dec_slv_sel && upstream_rd_en;
                downstream_wr_data <= upstream_wr_data;
                downstream_non_sec <= upstream_non_sec;
            end
        end else begin : g_no_forward_ff
            assign downstream_req_vld  = imux_req_vld;
            assign downstream_soft_rst = upstream_soft_rst;
            assign downstream_addr     = imux_addr;
            assign downstream_wr_en    = dec_slv_sel && upstream_wr_en;
            assign downstream_rd_en    = dec_slv_sel && upstream_rd_en;
            assign downstream_wr_data  = upstream_wr_data;
            assign downstream_non_sec  = upstream_non_sec;
        end
    endgenerate

    // dummy responder, ack without error and zero data
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            dummy_ack_vld <= 1'b0;
        end else begin
            dummy_ack_vld <= dec_dummy_sel;
        end
    end

    assign mux_ack_vld = downstream_ack_vld | dummy_ack_vld;
    assign mux_err = downstream_err;
    assign mux_rd_data = (downstream_ack_vld && !dummy_ack_vld) ? downstream_rd_data : '0;

    generate
        if (insert_backward_ff) begin : g_backward_ff
            always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
                if (!regdisp_disp_map_rst_n) begin
                    upstream_ack_vld <= 1'b0;
                    upstream_err     <= 1'b0;
                end else begin
                    upstream_ack_vld <= mux_ack_vld;
                    upstream_err     <= mux_err;
                end
            end
            always_ff @(posedge regdisp_disp_map_clk) begin
                upstream_rd_data <= mux_rd_data;
            end
        end else begin : g_no_backward_ff
            assign upstream_ack_vld = mux_ack_vld;
            assign upstream_err     = mux_err;
            assign upstream_rd_data = mux_rd_data;
        end
    endgenerate

    // slave ack and dummy ack never meet on the return path
    assert property (@(posedge regdisp_disp_map_clk) disable iff (!regdisp_disp_map_rst_n)
        !(downstream_ack_vld && dummy_ack_vld));

endmodule

`default_nettype wire

// File: verilog/regslv_slv_map.sv
`timescale 1ns/100ps
`default_nettype none

module regslv_slv_map (
    input  wire                                   regdisp_disp_map_clk,
    input  wire                                   regdisp_disp_map_rst_n,
    input  wire                                   req_vld,
    input  wire  [reg_map_pkg::addr_width-1:0]    addr,
    input  wire                                   wr_en,
    input  wire                                   rd_en,
    input  wire  [reg_map_pkg::data_width-1:0]    wr_data,
    input  wire                                   non_sec,
    input  wire                                   soft_rst,
    output logic                                  ack_vld,
    output logic                                  err,
    output logic [reg_map_pkg::data_width-1:0]    rd_data
);

    reg_map_pkg::reg_sel_e              sel;
    logic [reg_map_pkg::addr_width-1:0] word_addr;
    logic                               access_err;
    logic                               wr_accept;
    logic [reg_map_pkg::data_width-1:0] scratch_q;
    logic [reg_map_pkg::data_width-1:0] ctrl_q;
    logic [reg_map_pkg::data_width-1:0] wcount_q;
    logic [reg_map_pkg::data_width-1:0] rd_mux;

    assign word_addr = {addr[reg_map_pkg::addr_width-1:reg_map_pkg::byte_trunc_bits],
                        {reg_map_pkg::byte_trunc_bits{1'b0}}};

    always_comb begin
        case (word_addr)
            reg_map_pkg::reg_id_addr:      sel = reg_map_pkg::sel_id;
            reg_map_pkg::reg_scratch_addr: sel = reg_map_pkg::sel_scratch;
            reg_map_pkg::reg_ctrl_addr:    sel = reg_map_pkg::sel_ctrl;
            reg_map_pkg::reg_wcount_addr:  sel = reg_map_pkg::sel_wcount;
            default:                       sel = reg_map_pkg::sel_none;
        endcase
    end

    // id and counter are read only, ctrl is secure only
    always_comb begin
        case (sel)
            reg_map_pkg::sel_id:      access_err = wr_en;
            reg_map_pkg::sel_scratch: access_err = 1'b0;
            reg_map_pkg::sel_ctrl:    access_err = non_sec;
            reg_map_pkg::sel_wcount:  access_err = wr_en;
            default:                  access_err = 1'b1;
        endcase
    end

    always_comb begin
        case (sel)
            reg_map_pkg::sel_id:      rd_mux = reg_map_pkg::reg_id_value;
            reg_map_pkg::sel_scratch: rd_mux = scratch_q;
            reg_map_pkg::sel_ctrl:    rd_mux = ctrl_q;
            reg_map_pkg::sel_wcount:  rd_mux = wcount_q;
            default:                  rd_mux = '0;
        endcase
    end

    assign wr_accept = req_vld && wr_en && !access_err;

    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            scratch_q <= '0;
            ctrl_q    <= '0;
            wcount_q  <= '0;
        end else if (soft_rst) begin
            scratch_q <= '0;
            ctrl_q    <= '0;
            wcount_q  <= '0;
        end else if (wr_accept) begin
            if (sel == reg_map_pkg::sel_scratch) begin
                scratch_q <= wr_data;
            end
            if (sel == reg_map_pkg::sel_ctrl) begin
                ctrl_q <= wr_data;
            end
            wcount_q <= wcount_q + 1;
        end
    end

    // every request answered on the next edge
    always_ff @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            ack_vld <= 1'b0;
            err     <= 1'b0;
        end else begin
            ack_vld <= req_vld;
            err     <= req_vld && access_err;
        end
    end

    always_ff @(posedge regdisp_disp_map_clk) begin
        rd_data <= (req_vld && rd_en && !access_err) ? rd_mux : '0;
    end

    // bridge never issues a read and a write at once
    assert property (@(posedge regdisp_disp_map_clk) disable iff (!regdisp_disp_map_rst_n)
        req_vld |-> !(wr_en && rd_en));

endmodule

`default_nettype wire

// File: verilog/reg_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module reg_subsys_top (
    input  wire                                   regdisp_disp_map_clk,
    input  wire                                   regdisp_disp_map_rst_n,
    input  wire                                   wb_cyc,
    input  wire                                   wb_stb,
    input  wire                                   wb_we,
    input  wire  [reg_map_pkg::addr_width-1:0]    wb_adr,
    input  wire  [reg_map_pkg::data_width-1:0]    wb_dat_w,
    output wire                                   wb_ack,
    output wire                                   wb_err,
    output wire  [reg_map_pkg::data_width-1:0]    wb_dat_r,
    input  wire                                   non_sec,
    input  wire                                   soft_rst
);

    // bridge to dispatcher
    wire                               req_vld;
    wire [reg_map_pkg::addr_width-1:0] req_addr;
    wire                               req_wr_en;
    wire                               req_rd_en;
    wire [reg_map_pkg::data_width-1:0] req_wr_data;
    wire                               req_non_sec;
    wire                               req_soft_rst;
    wire                               rsp_ack_vld;
    wire                               rsp_err;
    wire [reg_map_pkg::data_width-1:0] rsp_rd_data;

    // dispatcher to slave
    wire                               slv_req_vld;
    wire [reg_map_pkg::addr_width-1:0] slv_addr;
    wire                               slv_wr_en;
    wire                               slv_rd_en;
    wire [reg_map_pkg::data_width-1:0] slv_wr_data;
    wire                               slv_non_sec;
    wire                               slv_soft_rst;
    wire                               slv_ack_vld;
    wire                               slv_err;
    wire [reg_map_pkg::data_width-1:0] slv_rd_data;

    wb_reg_bridge u_bridge (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .wb_cyc                 (wb_cyc),
        .wb_stb                 (wb_stb),
        .wb_we                  (wb_we),
        .wb_adr                 (wb_adr),
        .wb_dat_w               (wb_dat_w),
        .non_sec                (non_sec),
        .soft_rst               (soft_rst),
        .ack_vld                (rsp_ack_vld),
        .err                    (rsp_err),
        .rd_data                (rsp_rd_data),
        .wb_ack                 (wb_ack),
        .wb_err                 (wb_err),
        .wb_dat_r               (wb_dat_r),
        .req_vld                (req_vld),
        .addr                   (req_addr),
        .wr_en                  (req_wr_en),
        .rd_en                  (req_rd_en),
        .wr_data                (req_wr_data),
        .req_non_sec            (req_non_sec),
        .req_soft_rst           (req_soft_rst)
    );

    regdisp_disp_map #(
        .insert_forward_ff  (1'b1),
        .insert_backward_ff (1'b0)
    ) u_disp (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .upstream_req_vld       (req_vld),
        .upstream_addr          (req_addr),
        .upstream_wr_en         (req_wr_en),
        .upstream_rd_en         (req_rd_en),
        .upstream_wr_data       (req_wr_data),
        .upstream_non_sec       (req_non_sec),
        .upstream_soft_rst      (req_soft_rst),
        .upstream_ack_vld       (rsp_ack_vld),
        .upstream_err           (rsp_err),
        .upstream_rd_data       (rsp_rd_data),
        .downstream_req_vld     (slv_req_vld),
        .downstream_addr        (slv_addr),
        .downstream_wr_en       (slv_wr_en),
        .downstream_rd_en       (slv_rd_en),
        .downstream_wr_data     (slv_wr_data),
        .downstream_non_sec     (slv_non_sec),
        .downstream_soft_rst    (slv_soft_rst),
        .downstream_ack_vld     (slv_ack_vld),
        .downstream_err         (slv_err),
        .downstream_rd_data     (slv_rd_data)
    );

    regslv_slv_map u_slv (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .req_vld                (slv_req_vld),
        .addr                   (slv_addr),
        .wr_en                  (slv_wr_en),
        .rd_en                  (slv_rd_en),
        .wr_data                (slv_wr_data),
        .non_sec                (slv_non_sec),
        .soft_rst               (slv_soft_rst),
        .ack_vld                (slv_ack_vld),
        .err                    (slv_err),
        .rd_data                (slv_rd_data)
    );

endmodule

`default_nettype wire

// File: tests/reg_subsys_checker.sv
`timescale 1ns/100ps
`default_nettype none

module reg_subsys_checker (
    input  wire         regdisp_disp_map_clk,
    input  wire         regdisp_disp_map_rst_n,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [15:0] wb_adr,
    input  wire  [31:0] wb_dat_w,
    input  wire         wb_ack,
    input  wire         wb_err,
    input  wire  [31:0] wb_dat_r,
    input  wire         non_sec,
    input  wire         soft_rst,
    output int          error_count,
    output int          resp_count
);

    logic [31:0] scratch_m;
    logic [31:0] ctrl_m;
    logic [31:0] wcount_m;
    logic [32:0] expected;
    logic [15:0] word;

    // bit 32 is the expected err, bits 31:0 the expected read data
    function automatic logic [32:0] expect_response(
        input logic [15:0] adr,
        input logic        we,
        input logic        ns,
        input logic [31:0] scratch_v,
        input logic [31:0] ctrl_v,
        input logic [31:0] wcount_v
    );
        logic [15:0]           word_adr;
        reg_map_pkg::reg_sel_e sel;
        logic                  bad;
        logic [31:0]           data;
        word_adr = {adr[15:2], 2'b00};
        // outside the window the dummy answers
        if (word_adr >= 16'h12c8) begin
            return {1'b0, 32'h0};
        end
        case (word_adr)
            16'h0000: sel = reg_map_pkg::sel_id;
            16'h0004: sel = reg_map_pkg::sel_scratch;
            16'h0008: sel = reg_map_pkg::sel_ctrl;
            16'h000c: sel = reg_map_pkg::sel_wcount;
            default:  sel = reg_map_pkg::sel_none;
        endcase
        bad = 1'b0;
        data = 32'h0;
        case (sel)
            reg_map_pkg::sel_id: begin
                bad = we;
                data = 32'h52454731;
            end
            reg_map_pkg::sel_scratch: data = scratch_v;
            reg_map_pkg::sel_ctrl: begin
                bad = ns;
                data = ctrl_v;
            end
            reg_map_pkg::sel_wcount: begin
                bad = we;
                data = wcount_v;
            end
            default: bad = 1'b1;
        endcase
        if (bad || we) begin
            data = 32'h0;
        end
        return {bad, data};
    endfunction

    always @(posedge regdisp_disp_map_clk or negedge regdisp_disp_map_rst_n) begin
        if (!regdisp_disp_map_rst_n) begin
            scratch_m = 32'h0;
            ctrl_m = 32'h0;
            wcount_m = 32'h0;
            error_count = 0;
            resp_count = 0;
        end else if (soft_rst) begin
            scratch_m = 32'h0;
            ctrl_m = 32'h0;
            wcount_m = 32'h0;
        end else if (wb_ack || wb_err) begin
            resp_count = resp_count + 1;
            if (wb_ack && wb_err) begin
                $display("ack and err both high for address %h", wb_adr);
                error_count = error_count + 1;
            end
            if (!(wb_cyc && wb_stb)) begin
                $display("response arrived while no Wishbone cycle was open");
                error_count = error_count + 1;
            end
            expected = expect_response(wb_adr, wb_we, non_sec, scratch_m, ctrl_m, wcount_m);
            if (wb_err !== expected[32]) begin
                $display("Fail wb_err at address %h: expected %h, got %h",
                         wb_adr, expected[32], wb_err);
                error_count = error_count + 1;
            end
            if (!wb_we && wb_dat_r !== expected[31:0]) begin
                $display("Fail wb_dat_r at address %h: expected %h, got %h",
                         wb_adr, expected[31:0], wb_dat_r);
                error_count = error_count + 1;
            end
            // accepted writes inside the window update the model
            word = {wb_adr[15:2], 2'b00};
            if (wb_we && !expected[32] && word < 16'h12c8) begin
                if (word == 16'h0004) begin
                    scratch_m = wb_dat_w;
                end
                if (word == 16'h0008) begin
                    ctrl_m = wb_dat_w;
                end
                wcount_m = wcount_m + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/reg_subsys_tb.sv
`timescale 1ns/100ps
`default_nettype none

module reg_subsys_tb;

    localparam int num_trans = 38;
    localparam int timeout_cycles = 10 * num_trans + 100;

    logic        regdisp_disp_map_clk = 1'b0;
    logic        regdisp_disp_map_rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic        non_sec;
    logic        soft_rst;
    wire         wb_ack;
    wire         wb_err;
    wire  [31:0] wb_dat_r;

    int          error_count;
    int          resp_count;
    int          issued = 0;
    int          tb_errors = 0;
    int          total_errors;
    int          cycle_count = 0;
    int          i;
    logic [31:0] data;
    reg_map_pkg::bridge_state_e stuck_state;

    always #10 regdisp_disp_map_clk = ~regdisp_disp_map_clk;

    reg_subsys_top DUT (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .wb_cyc                 (wb_cyc),
        .wb_stb                 (wb_stb),
        .wb_we                  (wb_we),
        .wb_adr                 (wb_adr),
        .wb_dat_w               (wb_dat_w),
        .wb_ack                 (wb_ack),
        .wb_err                 (wb_err),
        .wb_dat_r               (wb_dat_r),
        .non_sec                (non_sec),
        .soft_rst               (soft_rst)
    );

    reg_subsys_checker u_checker (
        .regdisp_disp_map_clk   (regdisp_disp_map_clk),
        .regdisp_disp_map_rst_n (regdisp_disp_map_rst_n),
        .wb_cyc                 (wb_cyc),
        .wb_stb                 (wb_stb),
        .wb_we                  (wb_we),
        .wb_adr                 (wb_adr),
        .wb_dat_w               (wb_dat_w),
        .wb_ack                 (wb_ack),
        .wb_err                 (wb_err),
        .wb_dat_r               (wb_dat_r),
        .non_sec                (non_sec),
        .soft_rst               (soft_rst),
        .error_count            (error_count),
        .resp_count             (resp_count)
    );

    // one Wishbone cycle, held until ack or err
    task automatic bus_cycle(input logic we, input logic [15:0] adr,
                             input logic [31:0] wdata, input logic ns);
        @(posedge regdisp_disp_map_clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdata;
        non_sec <= ns;
        @(posedge regdisp_disp_map_clk);
        while (!(wb_ack || wb_err)) begin
            @(posedge regdisp_disp_map_clk);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        non_sec <= 1'b0;
        issued = issued + 1;
    endtask

    task automatic write_word(input logic [15:0] adr, input logic [31:0] wdata,
                              input logic ns);
        bus_cycle(1'b1, adr, wdata, ns);
    endtask

    task automatic read_word(input logic [15:0] adr, input logic ns);
        bus_cycle(1'b0, adr, 32'h0, ns);
    endtask

    task automatic pulse_soft_reset;
        @(posedge regdisp_disp_map_clk);
        soft_rst <= 1'b1;
        @(posedge regdisp_disp_map_clk);
        soft_rst <= 1'b0;
    endtask

    // stuck run guard
    always @(posedge regdisp_disp_map_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            stuck_state = DUT.u_bridge.state;
            $display("timeout after %0d cycles, no response from the DUT, bridge in %s",
                     cycle_count, stuck_state.name());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(7538));
        regdisp_disp_map_rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 16'h0;
        wb_dat_w = 32'h0;
        non_sec = 1'b0;
        soft_rst = 1'b0;
        repeat (2) @(posedge regdisp_disp_map_clk);
        regdisp_disp_map_rst_n <= 1'b1;

        // scratch with random data
        for (i = 0; i < 8; i++) begin
            data = $urandom;
            write_word(16'h0004, data, 1'b0);
            read_word(16'h0004, 1'b0);
        end

        // identifier is read only
        read_word(16'h0000, 1'b0);
        write_word(16'h0000, 32'hdeadbeef, 1'b0);
        read_word(16'h0000, 1'b0);

        // control is secure only
        write_word(16'h0008, 32'h0000a5a5, 1'b0);
        read_word(16'h0008, 1'b0);
        write_word(16'h0008, 32'hffff0000, 1'b1);
        read_word(16'h0008, 1'b1);
        read_word(16'h0008, 1'b0);

        read_word(16'h000c, 1'b0);
        write_word(16'h000c, 32'h00000055, 1'b0);
        read_word(16'h000c, 1'b0);

        // dummy above the window, unmapped hole inside it
        read_word(16'h12c8, 1'b0);
        write_word(16'h12c8, 32'h12345678, 1'b0);
        read_word(16'hfffc, 1'b0);
        read_word(16'h0100, 1'b0);
        write_word(16'h0100, 32'h00000001, 1'b0);

        write_word(16'h0004, 32'hcafef00d, 1'b0);
        write_word(16'h0008, 32'h00000003, 1'b0);
        pulse_soft_reset();
        read_word(16'h0004, 1'b0);
        read_word(16'h0008, 1'b0);
        read_word(16'h000c, 1'b0);
        read_word(16'h0000, 1'b0);

        repeat (3) @(posedge regdisp_disp_map_clk);
        if (resp_count != issued) begin
            $display("checker saw %0d responses for %0d bus cycles", resp_count, issued);
            tb_errors = tb_errors + 1;
        end
        total_errors = error_count + tb_errors;
        $display("errors: %0d, responses checked: %0d", total_errors, resp_count);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/reg_map_pkg.sv
verilog/wb_reg_bridge.sv
verilog/regdisp_disp_map.sv
verilog/regslv_slv_map.sv
verilog/reg_subsys_top.sv
tests/reg_subsys_checker.sv
tests/reg_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= reg_subsys_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
